// ==== rtl/id_settings.svh ====
////////////////////
// RV32I only. Widths and field positions are fixed by the ISA encoding
// Changing them breaks the immediate layouts in the operand path
////////////////////
`ifndef ID_SETTINGS_SVH
`define ID_SETTINGS_SVH

// Data, PC and instruction width
`define ID_XLEN     32
// Register file index width
`define ID_REG_AW   5
// Register field positions in the instruction word
`define ID_RS1_LSB  15
`define ID_RS2_LSB  20
`define ID_RD_LSB   7
// Link offset for JAL and JALR, no compressed support
`define ID_PC_INCR  4

`endif

// ==== rtl/rv_isa_pkg.sv ====
////////////////////
// ISA-side types for the decode stage, RV32I base opcodes only
////////////////////
`include "id_settings.svh"

package rv_isa_pkg;

  // Data word, PC or instruction
  typedef logic [`ID_XLEN-1:0] word_t;
  // Register index
  typedef logic [`ID_REG_AW-1:0] reg_addr_t;

  // Major opcodes handled by the decoder
  typedef enum logic [6:0] {
    OPC_OP     = 7'h33,
    OPC_OP_IMM = 7'h13,
    OPC_LUI    = 7'h37,
    OPC_AUIPC  = 7'h17,
    OPC_JAL    = 7'h6f,
    OPC_JALR   = 7'h67,
    OPC_BRANCH = 7'h63
  } opcode_e;

  // ALU operators, arithmetic and logic first
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    // Branch compares
    ALU_EQ,
    ALU_NE,
    ALU_LT,
    ALU_GE,
    ALU_LTU,
    ALU_GEU
  } alu_op_e;

endpackage

// ==== rtl/id_ctrl_pkg.sv ====
////////////////////
// Select encodings shared by decoder, operand path and bypass logic
////////////////////
package id_ctrl_pkg;

  // Operand A source
  typedef enum logic [1:0] {
    OP_A_REG,
    OP_A_PC,
    OP_A_ZERO,
    OP_A_NONE
  } op_a_sel_e;

  // Operand B source
  typedef enum logic [1:0] {
    OP_B_REG,
    OP_B_IMM,
    OP_B_PCINCR,
    OP_B_NONE
  } op_b_sel_e;

  // Immediate feeding operand B
  typedef enum logic [1:0] {
    IMMB_I,
    IMMB_U,
    IMMB_SHAMT
  } imm_b_sel_e;

  // Operand C carries only the branch target
  typedef enum logic {
    OP_C_BCH,
    OP_C_NONE
  } op_c_sel_e;

  // Jump target source
  typedef enum logic {
    TGT_JAL,
    TGT_JALR
  } tgt_sel_e;

  // Forwarding source for rs1 and rs2
  typedef enum logic [1:0] {
    SEL_REGFILE,
    SEL_FW_EX,
    SEL_FW_WB
  } fw_sel_e;

endpackage

// ==== rtl/operand_sel_if.sv ====
////////////////////
// Level bundle, no handshake. Valid while the instruction input is stable
////////////////////
`timescale 1ns/1ps

interface operand_sel_if;

  // Operand selects from the decoder
  id_ctrl_pkg::op_a_sel_e  op_a_sel;
  id_ctrl_pkg::op_b_sel_e  op_b_sel;
  id_ctrl_pkg::imm_b_sel_e imm_b_sel;
  id_ctrl_pkg::op_c_sel_e  op_c_sel;
  // Jump target select
  id_ctrl_pkg::tgt_sel_e   tgt_sel;

  // Decoder side drives
  modport dec_mp (
    output op_a_sel, op_b_sel, imm_b_sel, op_c_sel, tgt_sel
  );

  // Operand path side reads
  modport opr_mp (
    input op_a_sel, op_b_sel, imm_b_sel, op_c_sel, tgt_sel
  );

endinterface

// ==== rtl/instr_decoder.sv ====
////////////////////
// RV32I ALU, upper-immediate, jump and branch opcodes only
// Loads, stores, CSR, system and M encodings decode as illegal
////////////////////
`timescale 1ns/1ps

module instr_decoder (
  input  rv_isa_pkg::word_t   instr_i,
  operand_sel_if.dec_mp       sel,
  output logic                alu_en_o,
  output logic                bch_o,
  output logic                jmp_o,
  output logic                rf_we_o,
  output logic                illegal_o,
  output rv_isa_pkg::alu_op_e alu_op_o
);

  rv_isa_pkg::opcode_e opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;

  assign opcode = rv_isa_pkg::opcode_e'(instr_i[6:0]);
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // Shared funct3 map for OP and OP_IMM
  // alt selects SUB over ADD and SRA over SRL
  function automatic rv_isa_pkg::alu_op_e alu_from_f3(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  alu_from_f3 = alt ? rv_isa_pkg::ALU_SUB : rv_isa_pkg::ALU_ADD;
      3'b001:  alu_from_f3 = rv_isa_pkg::ALU_SLL;
      3'b010:  alu_from_f3 = rv_isa_pkg::ALU_SLT;
      3'b011:  alu_from_f3 = rv_isa_pkg::ALU_SLTU;
      3'b100:  alu_from_f3 = rv_isa_pkg::ALU_XOR;
      3'b101:  alu_from_f3 = alt ? rv_isa_pkg::ALU_SRA : rv_isa_pkg::ALU_SRL;
      3'b110:  alu_from_f3 = rv_isa_pkg::ALU_OR;
      default: alu_from_f3 = rv_isa_pkg::ALU_AND;
    endcase
  endfunction

  always_comb begin
    // Defaults for a legal plain ALU op
    alu_en_o      = 1'b1;
    bch_o         = 1'b0;
    jmp_o         = 1'b0;
    rf_we_o       = 1'b1;
    illegal_o     = 1'b0;
    alu_op_o      = rv_isa_pkg::ALU_ADD;
    sel.op_a_sel  = id_ctrl_pkg::OP_A_REG;
    sel.op_b_sel  = id_ctrl_pkg::OP_B_REG;
    sel.imm_b_sel = id_ctrl_pkg::IMMB_I;
    sel.op_c_sel  = id_ctrl_pkg::OP_C_NONE;
    sel.tgt_sel   = id_ctrl_pkg::TGT_JAL;

    case (opcode)
      rv_isa_pkg::OPC_OP: begin
        alu_op_o = alu_from_f3(funct3, funct7[5]);
        // funct7 alternate bit only valid for SUB and SRA
        if (!(funct7 == 7'b0000000 ||
              (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)))) begin
          illegal_o = 1'b1;
        end
      end
      rv_isa_pkg::OPC_OP_IMM: begin
        sel.op_b_sel = id_ctrl_pkg::OP_B_IMM;
        // No SUBI, alt bit only matters for right shifts
        alu_op_o     = alu_from_f3(funct3, funct3 == 3'b101 && funct7[5]);
        if (funct3 == 3'b001 || funct3 == 3'b101) begin
          sel.imm_b_sel = id_ctrl_pkg::IMMB_SHAMT;
          if (!(funct7 == 7'b0000000 || (funct3 == 3'b101 && funct7 == 7'b0100000))) begin
            illegal_o = 1'b1;
          end
        end
      end
      rv_isa_pkg::OPC_LUI: begin
        sel.op_a_sel  = id_ctrl_pkg::OP_A_ZERO;
        sel.op_b_sel  = id_ctrl_pkg::OP_B_IMM;
        sel.imm_b_sel = id_ctrl_pkg::IMMB_U;
      end
      rv_isa_pkg::OPC_AUIPC: begin
        sel.op_a_sel  = id_ctrl_pkg::OP_A_PC;
        sel.op_b_sel  = id_ctrl_pkg::OP_B_IMM;
        sel.imm_b_sel = id_ctrl_pkg::IMMB_U;
      end
      rv_isa_pkg::OPC_JAL, rv_isa_pkg::OPC_JALR: begin
        // Link value PC + 4 computed by the ALU
        jmp_o        = 1'b1;
        sel.op_a_sel = id_ctrl_pkg::OP_A_PC;
        sel.op_b_sel = id_ctrl_pkg::OP_B_PCINCR;
        if (opcode == rv_isa_pkg::OPC_JALR) begin
          sel.tgt_sel = id_ctrl_pkg::TGT_JALR;
          illegal_o   = (funct3 != 3'b000);
        end
      end
      rv_isa_pkg::OPC_BRANCH: begin
        bch_o        = 1'b1;
        rf_we_o      = 1'b0;
        sel.op_c_sel = id_ctrl_pkg::OP_C_BCH;
        case (funct3)
          3'b000:  alu_op_o = rv_isa_pkg::ALU_EQ;
          3'b001:  alu_op_o = rv_isa_pkg::ALU_NE;
          3'b100:  alu_op_o = rv_isa_pkg::ALU_LT;
          3'b101:  alu_op_o = rv_isa_pkg::ALU_GE;
          3'b110:  alu_op_o = rv_isa_pkg::ALU_LTU;
          3'b111:  alu_op_o = rv_isa_pkg::ALU_GEU;
          default: illegal_o = 1'b1;
        endcase
      end
      default: illegal_o = 1'b1;
    endcase

    // Illegal encodings use no unit and no operand
    if (illegal_o) begin
      alu_en_o     = 1'b0;
      rf_we_o      = 1'b0;
      bch_o        = 1'b0;
      jmp_o        = 1'b0;
      sel.op_a_sel = id_ctrl_pkg::OP_A_NONE;
      sel.op_b_sel = id_ctrl_pkg::OP_B_NONE;
      sel.op_c_sel = id_ctrl_pkg::OP_C_NONE;
    end
  end

endmodule

// ==== rtl/operand_path.sv ====
////////////////////
// Purely combinational. Forwarding selects come from outside bypass logic
////////////////////
`timescale 1ns/1ps
`include "id_settings.svh"

module operand_path (
  input  rv_isa_pkg::word_t    instr_i,
  input  rv_isa_pkg::word_t    pc_i,
  input  rv_isa_pkg::word_t    rf_rdata_a_i,
  input  rv_isa_pkg::word_t    rf_rdata_b_i,
  input  rv_isa_pkg::word_t    wdata_ex_i,
  input  rv_isa_pkg::word_t    wdata_wb_i,
  input  id_ctrl_pkg::fw_sel_e fw_a_sel_i,
  input  id_ctrl_pkg::fw_sel_e fw_b_sel_i,
  operand_sel_if.opr_mp        sel,
  output rv_isa_pkg::word_t    operand_a_o,
  output rv_isa_pkg::word_t    operand_b_o,
  output rv_isa_pkg::word_t    operand_c_o,
  output rv_isa_pkg::word_t    jmp_target_o
);

  rv_isa_pkg::word_t imm_i;
  rv_isa_pkg::word_t imm_u;
  rv_isa_pkg::word_t imm_b;
  rv_isa_pkg::word_t imm_j;
  rv_isa_pkg::word_t imm_shamt;
  rv_isa_pkg::word_t imm_op_b;
  rv_isa_pkg::word_t operand_a_fw;
  rv_isa_pkg::word_t operand_b_fw;
  rv_isa_pkg::word_t bch_target;
  rv_isa_pkg::word_t jalr_sum;

  ////////////////////
  // Immediates
  ////////////////////
  assign imm_i     = {{(`ID_XLEN-12){instr_i[31]}}, instr_i[31:20]};
  assign imm_u     = {instr_i[31:12], 12'b0};
  // Branch and jump offsets are halfword aligned
  assign imm_b     = {{(`ID_XLEN-13){instr_i[31]}}, instr_i[31], instr_i[7],
                      instr_i[30:25], instr_i[11:8], 1'b0};
  assign imm_j     = {{(`ID_XLEN-21){instr_i[31]}}, instr_i[31], instr_i[19:12],
                      instr_i[20], instr_i[30:21], 1'b0};
  // Zero-extended shift amount
  assign imm_shamt = {{(`ID_XLEN-5){1'b0}}, instr_i[24:20]};

  ////////////////////
  // Forwarding
  ////////////////////
  function automatic rv_isa_pkg::word_t fw_mux(input id_ctrl_pkg::fw_sel_e fw_sel,
                                               input rv_isa_pkg::word_t rf_data,
                                               input rv_isa_pkg::word_t ex_data,
                                               input rv_isa_pkg::word_t wb_data);
    case (fw_sel)
      id_ctrl_pkg::SEL_FW_EX: fw_mux = ex_data;
      id_ctrl_pkg::SEL_FW_WB: fw_mux = wb_data;
      default:                fw_mux = rf_data;
    endcase
  endfunction

  assign operand_a_fw = fw_mux(fw_a_sel_i, rf_rdata_a_i, wdata_ex_i, wdata_wb_i);
  assign operand_b_fw = fw_mux(fw_b_sel_i, rf_rdata_b_i, wdata_ex_i, wdata_wb_i);

  ////////////////////
  // Operand muxes
  ////////////////////
  always_comb begin
    case (sel.imm_b_sel)
      id_ctrl_pkg::IMMB_U:     imm_op_b = imm_u;
      id_ctrl_pkg::IMMB_SHAMT: imm_op_b = imm_shamt;
      default:                 imm_op_b = imm_i;
    endcase
  end

  always_comb begin
    case (sel.op_a_sel)
      id_ctrl_pkg::OP_A_PC:   operand_a_o = pc_i;
      id_ctrl_pkg::OP_A_ZERO: operand_a_o = '0;
      default:                operand_a_o = operand_a_fw;
    endcase
  end

  always_comb begin
    case (sel.op_b_sel)
      id_ctrl_pkg::OP_B_IMM:    operand_b_o = imm_op_b;
      id_ctrl_pkg::OP_B_PCINCR: operand_b_o = rv_isa_pkg::word_t'(`ID_PC_INCR);
      default:                  operand_b_o = operand_b_fw;
    endcase
  end

  ////////////////////
  // Targets
  ////////////////////
  assign bch_target  = pc_i + imm_b;
  assign operand_c_o = (sel.op_c_sel == id_ctrl_pkg::OP_C_BCH) ? bch_target : '0;

  // JALR reuses the rs1 forward path
  // LSB cleared per ISA
  assign jalr_sum     = operand_a_fw + imm_i;
  assign jmp_target_o = (sel.tgt_sel == id_ctrl_pkg::TGT_JALR) ? {jalr_sum[`ID_XLEN-1:1], 1'b0}
                                                               : pc_i + imm_j;

endmodule

// ==== rtl/id_ex_register.sv ====
////////////////////
// One instruction in flight. Fetch must hold its inputs while id_ready_o is low
////////////////////
`timescale 1ns/1ps

module id_ex_register (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 instr_valid_i,
  input  logic                 kill_i,
  input  logic                 halt_i,
  input  logic                 ex_ready_i,
  input  rv_isa_pkg::word_t    pc_i,
  input  rv_isa_pkg::reg_addr_t rd_i,
  input  logic                 alu_en_i,
  input  logic                 bch_i,
  input  logic                 jmp_i,
  input  logic                 rf_we_i,
  input  logic                 illegal_i,
  input  rv_isa_pkg::alu_op_e  alu_op_i,
  input  rv_isa_pkg::word_t    operand_a_i,
  input  rv_isa_pkg::word_t    operand_b_i,
  input  rv_isa_pkg::word_t    operand_c_i,
  input  logic                 op_a_used_i,
  input  logic                 op_b_used_i,
  input  logic                 op_c_used_i,
  output logic                 id_valid_o,
  output logic                 id_ready_o,
  output logic                 ex_valid_o,
  output logic                 ex_alu_en_o,
  output rv_isa_pkg::alu_op_e  ex_alu_op_o,
  output logic                 ex_bch_o,
  output logic                 ex_jmp_o,
  output rv_isa_pkg::word_t    ex_operand_a_o,
  output rv_isa_pkg::word_t    ex_operand_b_o,
  output rv_isa_pkg::word_t    ex_operand_c_o,
  output logic                 ex_rf_we_o,
  output rv_isa_pkg::reg_addr_t ex_rf_waddr_o,
  output logic                 ex_illegal_o,
  output rv_isa_pkg::word_t    ex_pc_o
);

  logic xfer;

  // Halt stalls both sides, kill flushes ID regardless of EX
  assign id_valid_o = instr_valid_i && !kill_i && !halt_i;
  assign id_ready_o = kill_i || (ex_ready_i && !halt_i);
  assign xfer       = id_valid_o && ex_ready_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_valid_o     <= 1'b0;
      ex_alu_en_o    <= 1'b0;
      ex_alu_op_o    <= rv_isa_pkg::ALU_SLTU;
      ex_bch_o       <= 1'b0;
      ex_jmp_o       <= 1'b0;
      ex_operand_a_o <= '0;
      ex_operand_b_o <= '0;
      ex_operand_c_o <= '0;
      ex_rf_we_o     <= 1'b0;
      ex_rf_waddr_o  <= '0;
      ex_illegal_o   <= 1'b0;
      ex_pc_o        <= '0;
    end else if (xfer) begin
      ex_valid_o   <= 1'b1;
      ex_alu_en_o  <= alu_en_i;
      ex_rf_we_o   <= rf_we_i;
      ex_illegal_o <= illegal_i;
      ex_pc_o      <= pc_i;
      // Fields load only when their unit or operand is in use
      if (alu_en_i) begin
        ex_alu_op_o <= alu_op_i;
        ex_bch_o    <= bch_i;
        ex_jmp_o    <= jmp_i;
      end
      if (op_a_used_i) begin
        ex_operand_a_o <= operand_a_i;
      end
      if (op_b_used_i) begin
        ex_operand_b_o <= operand_b_i;
      end
      if (op_c_used_i) begin
        ex_operand_c_o <= operand_c_i;
      end
      if (rf_we_i) begin
        ex_rf_waddr_o <= rd_i;
      end
    end else if (ex_ready_i) begin
      // EX consumed its instruction, nothing new
      ex_valid_o <= 1'b0;
    end
  end

endmodule

// ==== rtl/decode_stage.sv ====
////////////////////
// Decode stage top. Register file and bypass control live outside
////////////////////
`timescale 1ns/1ps
`include "id_settings.svh"

module decode_stage (
  input  logic                  clk,
  input  logic                  rst_n,
  // Fetch side
  input  rv_isa_pkg::word_t     instr_i,
  input  rv_isa_pkg::word_t     pc_i,
  input  logic                  instr_valid_i,
  // Controller and bypass
  input  logic                  kill_i,
  input  logic                  halt_i,
  input  id_ctrl_pkg::fw_sel_e  fw_a_sel_i,
  input  id_ctrl_pkg::fw_sel_e  fw_b_sel_i,
  // Register file and write-back data
  input  rv_isa_pkg::word_t     rf_rdata_a_i,
  input  rv_isa_pkg::word_t     rf_rdata_b_i,
  input  rv_isa_pkg::word_t     wdata_ex_i,
  input  rv_isa_pkg::word_t     wdata_wb_i,
  input  logic                  ex_ready_i,
  output rv_isa_pkg::reg_addr_t rf_raddr_a_o,
  output rv_isa_pkg::reg_addr_t rf_raddr_b_o,
  output rv_isa_pkg::word_t     jmp_target_o,
  output logic                  id_valid_o,
  output logic                  id_ready_o,
  // ID/EX pipeline
  output logic                  ex_valid_o,
  output logic                  ex_alu_en_o,
  output rv_isa_pkg::alu_op_e   ex_alu_op_o,
  output logic                  ex_bch_o,
  output logic                  ex_jmp_o,
  output rv_isa_pkg::word_t     ex_operand_a_o,
  output rv_isa_pkg::word_t     ex_operand_b_o,
  output rv_isa_pkg::word_t     ex_operand_c_o,
  output logic                  ex_rf_we_o,
  output rv_isa_pkg::reg_addr_t ex_rf_waddr_o,
  output logic                  ex_illegal_o,
  output rv_isa_pkg::word_t     ex_pc_o
);

  operand_sel_if       sel_if ();
  rv_isa_pkg::reg_addr_t rd;
  rv_isa_pkg::alu_op_e alu_op;
  rv_isa_pkg::word_t   operand_a;
  rv_isa_pkg::word_t   operand_b;
  rv_isa_pkg::word_t   operand_c;
  logic                alu_en;
  logic                bch;
  logic                jmp;
  logic                rf_we;
  logic                illegal;

  // Register fields
  assign rf_raddr_a_o = instr_i[`ID_RS1_LSB +: `ID_REG_AW];
  assign rf_raddr_b_o = instr_i[`ID_RS2_LSB +: `ID_REG_AW];
  assign rd           = instr_i[`ID_RD_LSB +: `ID_REG_AW];

  instr_decoder decoder_i (
    .instr_i   (instr_i),
    .sel       (sel_if),
    .alu_en_o  (alu_en),
    .bch_o     (bch),
    .jmp_o     (jmp),
    .rf_we_o   (rf_we),
    .illegal_o (illegal),
    .alu_op_o  (alu_op)
  );

  operand_path operand_path_i (
    .instr_i      (instr_i),
    .pc_i         (pc_i),
    .rf_rdata_a_i (rf_rdata_a_i),
    .rf_rdata_b_i (rf_rdata_b_i),
    .wdata_ex_i   (wdata_ex_i),
    .wdata_wb_i   (wdata_wb_i),
    .fw_a_sel_i   (fw_a_sel_i),
    .fw_b_sel_i   (fw_b_sel_i),
    .sel          (sel_if),
    .operand_a_o  (operand_a),
    .operand_b_o  (operand_b),
    .operand_c_o  (operand_c),
    .jmp_target_o (jmp_target_o)
  );

  id_ex_register id_ex_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .instr_valid_i  (instr_valid_i),
    .kill_i         (kill_i),
    .halt_i         (halt_i),
    .ex_ready_i     (ex_ready_i),
    .pc_i           (pc_i),
    .rd_i           (rd),
    .alu_en_i       (alu_en),
    .bch_i          (bch),
    .jmp_i          (jmp),
    .rf_we_i        (rf_we),
    .illegal_i      (illegal),
    .alu_op_i       (alu_op),
    .operand_a_i    (operand_a),
    .operand_b_i    (operand_b),
    .operand_c_i    (operand_c),
    // Operand in use when its select is not NONE
    .op_a_used_i    (sel_if.op_a_sel != id_ctrl_pkg::OP_A_NONE),
    .op_b_used_i    (sel_if.op_b_sel != id_ctrl_pkg::OP_B_NONE),
    .op_c_used_i    (sel_if.op_c_sel != id_ctrl_pkg::OP_C_NONE),
    .id_valid_o     (id_valid_o),
    .id_ready_o     (id_ready_o),
    .ex_valid_o     (ex_valid_o),
    .ex_alu_en_o    (ex_alu_en_o),
    .ex_alu_op_o    (ex_alu_op_o),
    .ex_bch_o       (ex_bch_o),
    .ex_jmp_o       (ex_jmp_o),
    .ex_operand_a_o (ex_operand_a_o),
    .ex_operand_b_o (ex_operand_b_o),
    .ex_operand_c_o (ex_operand_c_o),
    .ex_rf_we_o     (ex_rf_we_o),
    .ex_rf_waddr_o  (ex_rf_waddr_o),
    .ex_illegal_o   (ex_illegal_o),
    .ex_pc_o        (ex_pc_o)
  );

endmodule

// ==== bench/decode_checker.sv ====
////////////////////
// Watches every DUT port. Combinational outputs checked on rising edges
// ID/EX fields compared on the falling edge after each rising edge
////////////////////
`timescale 1ns/1ps

module decode_checker (
  input  logic                  clk,
  input  logic                  rst_n,
  input  rv_isa_pkg::word_t     instr_i,
  input  rv_isa_pkg::word_t     pc_i,
  input  logic                  instr_valid_i,
  input  logic                  kill_i,
  input  logic                  halt_i,
  input  id_ctrl_pkg::fw_sel_e  fw_a_sel_i,
  input  id_ctrl_pkg::fw_sel_e  fw_b_sel_i,
  input  rv_isa_pkg::word_t     rf_rdata_a_i,
  input  rv_isa_pkg::word_t     rf_rdata_b_i,
  input  rv_isa_pkg::word_t     wdata_ex_i,
  input  rv_isa_pkg::word_t     wdata_wb_i,
  input  logic                  ex_ready_i,
  input  rv_isa_pkg::reg_addr_t rf_raddr_a_o,
  input  rv_isa_pkg::reg_addr_t rf_raddr_b_o,
  input  rv_isa_pkg::word_t     jmp_target_o,
  input  logic                  id_valid_o,
  input  logic                  id_ready_o,
  input  logic                  ex_valid_o,
  input  logic                  ex_alu_en_o,
  input  rv_isa_pkg::alu_op_e   ex_alu_op_o,
  input  logic                  ex_bch_o,
  input  logic                  ex_jmp_o,
  input  rv_isa_pkg::word_t     ex_operand_a_o,
  input  rv_isa_pkg::word_t     ex_operand_b_o,
  input  rv_isa_pkg::word_t     ex_operand_c_o,
  input  logic                  ex_rf_we_o,
  input  rv_isa_pkg::reg_addr_t ex_rf_waddr_o,
  input  logic                  ex_illegal_o,
  input  rv_isa_pkg::word_t     ex_pc_o,
  output int                    mismatch_cnt_o
);

  // Expected fields of one decoded instruction
  // Same layout holds the ID/EX model
  typedef struct packed {
    logic                  legal;
    logic                  alu_en;
    logic                  bch;
    logic                  jmp;
    logic                  rf_we;
    rv_isa_pkg::alu_op_e   alu_op;
    logic                  a_used;
    logic                  b_used;
    logic                  c_used;
    rv_isa_pkg::word_t     opnd_a;
    rv_isa_pkg::word_t     opnd_b;
    rv_isa_pkg::word_t     opnd_c;
    rv_isa_pkg::reg_addr_t rd;
    rv_isa_pkg::word_t     pc;
    logic                  is_jump;
    rv_isa_pkg::word_t     target;
  } dec_t;

  dec_t exp_q[$];
  dec_t cur;
  dec_t nxt;
  dec_t mdl;
  logic m_valid;
  logic drop_pending;
  logic exp_idv;
  logic exp_idr;

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      mismatch_cnt_o = mismatch_cnt_o + 1;
      $display("FAILED at %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
    end
  endtask

  task automatic reset_model();
    m_valid      = 1'b0;
    drop_pending = 1'b0;
    mdl          = '0;
    mdl.legal    = 1'b1;
    mdl.alu_op   = rv_isa_pkg::ALU_SLTU;
    exp_q.delete();
  endtask

  ////////////////////
  // Reference decode
  ////////////////////
  function automatic rv_isa_pkg::word_t fwd(input id_ctrl_pkg::fw_sel_e s,
                                            input rv_isa_pkg::word_t rf);
    if (s == id_ctrl_pkg::SEL_FW_EX) return wdata_ex_i;
    if (s == id_ctrl_pkg::SEL_FW_WB) return wdata_wb_i;
    return rf;
  endfunction

  // funct3 table of the base ISA
  // alt picks SUB or SRA
  function automatic rv_isa_pkg::alu_op_e alu_ref(input logic [2:0] f3, input logic alt);
    case (f3)
      3'd0:    return alt ? rv_isa_pkg::ALU_SUB : rv_isa_pkg::ALU_ADD;
      3'd1:    return rv_isa_pkg::ALU_SLL;
      3'd2:    return rv_isa_pkg::ALU_SLT;
      3'd3:    return rv_isa_pkg::ALU_SLTU;
      3'd4:    return rv_isa_pkg::ALU_XOR;
      3'd5:    return alt ? rv_isa_pkg::ALU_SRA : rv_isa_pkg::ALU_SRL;
      3'd6:    return rv_isa_pkg::ALU_OR;
      default: return rv_isa_pkg::ALU_AND;
    endcase
  endfunction

  function automatic dec_t decode_ref();
    dec_t              r;
    logic [2:0]        f3;
    logic [6:0]        f7;
    rv_isa_pkg::word_t rs1;
    rv_isa_pkg::word_t imm_i;
    f3       = instr_i[14:12];
    f7       = instr_i[31:25];
    rs1      = fwd(fw_a_sel_i, rf_rdata_a_i);
    imm_i    = {{20{instr_i[31]}}, instr_i[31:20]};
    r        = '0;
    r.legal  = 1'b1;
    r.alu_en = 1'b1;
    r.rf_we  = 1'b1;
    r.a_used = 1'b1;
    r.b_used = 1'b1;
    r.alu_op = rv_isa_pkg::ALU_ADD;
    r.opnd_a = rs1;
    r.opnd_b = fwd(fw_b_sel_i, rf_rdata_b_i);
    r.rd     = instr_i[11:7];
    r.pc     = pc_i;
    case (instr_i[6:0])
      7'h33: begin
        r.legal  = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
        r.alu_op = alu_ref(f3, f7[5]);
      end
      7'h13: begin
        r.opnd_b = imm_i;
        r.alu_op = alu_ref(f3, 1'b0);
        if (f3 == 3'd1 || f3 == 3'd5) begin
          // Shift amount zero extended
          r.opnd_b = {27'b0, instr_i[24:20]};
          r.legal  = (f7 == 7'h00) || (f3 == 3'd5 && f7 == 7'h20);
          r.alu_op = alu_ref(f3, f7[5]);
        end
      end
      7'h37: begin
        r.opnd_a = '0;
        r.opnd_b = {instr_i[31:12], 12'h000};
      end
      7'h17: begin
        r.opnd_a = pc_i;
        r.opnd_b = {instr_i[31:12], 12'h000};
      end
      7'h6f, 7'h67: begin
        r.legal   = (instr_i[6:0] == 7'h6f) || (f3 == 3'd0);
        r.jmp     = 1'b1;
        r.is_jump = 1'b1;
        r.opnd_a  = pc_i;
        r.opnd_b  = 32'd4;
        r.target  = pc_i + {{12{instr_i[31]}}, instr_i[19:12], instr_i[20],
                            instr_i[30:21], 1'b0};
        if (instr_i[6:0] == 7'h67) begin
          r.target = (rs1 + imm_i) & ~32'd1;
        end
      end
      7'h63: begin
        r.bch    = 1'b1;
        r.rf_we  = 1'b0;
        r.c_used = 1'b1;
        r.opnd_c = pc_i + {{20{instr_i[31]}}, instr_i[7], instr_i[30:25],
                           instr_i[11:8], 1'b0};
        case (f3)
          3'd0:    r.alu_op = rv_isa_pkg::ALU_EQ;
          3'd1:    r.alu_op = rv_isa_pkg::ALU_NE;
          3'd4:    r.alu_op = rv_isa_pkg::ALU_LT;
          3'd5:    r.alu_op = rv_isa_pkg::ALU_GE;
          3'd6:    r.alu_op = rv_isa_pkg::ALU_LTU;
          3'd7:    r.alu_op = rv_isa_pkg::ALU_GEU;
          default: r.legal = 1'b0;
        endcase
      end
      default: r.legal = 1'b0;
    endcase
    // No unit and no operand in use
    if (!r.legal) begin
      r.alu_en  = 1'b0;
      r.bch     = 1'b0;
      r.jmp     = 1'b0;
      r.rf_we   = 1'b0;
      r.a_used  = 1'b0;
      r.b_used  = 1'b0;
      r.c_used  = 1'b0;
      r.is_jump = 1'b0;
    end
    return r;
  endfunction

  initial begin
    mismatch_cnt_o = 0;
    reset_model();
  end

  ////////////////////
  // Rising edge
  ////////////////////
  // Inputs change on falling edges so they are stable here
  always @(posedge clk) begin
    exp_idv = instr_valid_i && !kill_i && !halt_i;
    exp_idr = kill_i || (ex_ready_i && !halt_i);
    cur     = decode_ref();
    check_val("id_valid_o", exp_idv, id_valid_o);
    check_val("id_ready_o", exp_idr, id_ready_o);
    check_val("rf_raddr_a_o", instr_i[19:15], rf_raddr_a_o);
    check_val("rf_raddr_b_o", instr_i[24:20], rf_raddr_b_o);
    if (cur.is_jump) begin
      check_val("jmp_target_o", cur.target, jmp_target_o);
    end
    if (!rst_n) begin
      reset_model();
    end else if (exp_idv && ex_ready_i) begin
      exp_q.push_back(cur);
    end else if (ex_ready_i) begin
      drop_pending = 1'b1;
    end
  end

  ////////////////////
  // Falling edge
  ////////////////////
  always @(negedge clk) begin
    if (exp_q.size() != 0) begin
      nxt        = exp_q.pop_front();
      m_valid    = 1'b1;
      mdl.alu_en = nxt.alu_en;
      mdl.rf_we  = nxt.rf_we;
      mdl.legal  = nxt.legal;
      mdl.pc     = nxt.pc;
      // Gated fields keep their old value when unused
      if (nxt.alu_en) begin
        mdl.alu_op = nxt.alu_op;
        mdl.bch    = nxt.bch;
        mdl.jmp    = nxt.jmp;
      end
      if (nxt.a_used) begin
        mdl.opnd_a = nxt.opnd_a;
      end
      if (nxt.b_used) begin
        mdl.opnd_b = nxt.opnd_b;
      end
      if (nxt.c_used) begin
        mdl.opnd_c = nxt.opnd_c;
      end
      if (nxt.rf_we) begin
        mdl.rd = nxt.rd;
      end
    end else if (drop_pending) begin
      m_valid = 1'b0;
    end
    drop_pending = 1'b0;
    check_val("ex_valid_o", m_valid, ex_valid_o);
    check_val("ex_alu_en_o", mdl.alu_en, ex_alu_en_o);
    check_val("ex_alu_op_o", mdl.alu_op, ex_alu_op_o);
    check_val("ex_bch_o", mdl.bch, ex_bch_o);
    check_val("ex_jmp_o", mdl.jmp, ex_jmp_o);
    check_val("ex_operand_a_o", mdl.opnd_a, ex_operand_a_o);
    check_val("ex_operand_b_o", mdl.opnd_b, ex_operand_b_o);
    check_val("ex_operand_c_o", mdl.opnd_c, ex_operand_c_o);
    check_val("ex_rf_we_o", mdl.rf_we, ex_rf_we_o);
    check_val("ex_rf_waddr_o", mdl.rd, ex_rf_waddr_o);
    check_val("ex_illegal_o", !mdl.legal, ex_illegal_o);
    check_val("ex_pc_o", mdl.pc, ex_pc_o);
  end

endmodule

// ==== bench/decode_stage_tb.sv ====
////////////////////
// Random RV32I decode traffic from a fixed seed
// Fetch side holds its word until the stage is ready
////////////////////
`timescale 1ns/1ps

module decode_stage_tb;

  localparam int NUM_CYCLES     = 3000;
  // Reset, drain and margin on top of the stimulus
  localparam int TIMEOUT_CYCLES = NUM_CYCLES + 1000;

  logic                  clk;
  logic                  rst_n;
  rv_isa_pkg::word_t     instr_i;
  rv_isa_pkg::word_t     pc_i;
  logic                  instr_valid_i;
  logic                  kill_i;
  logic                  halt_i;
  id_ctrl_pkg::fw_sel_e  fw_a_sel_i;
  id_ctrl_pkg::fw_sel_e  fw_b_sel_i;
  rv_isa_pkg::word_t     rf_rdata_a_i;
  rv_isa_pkg::word_t     rf_rdata_b_i;
  rv_isa_pkg::word_t     wdata_ex_i;
  rv_isa_pkg::word_t     wdata_wb_i;
  logic                  ex_ready_i;
  rv_isa_pkg::reg_addr_t rf_raddr_a_o;
  rv_isa_pkg::reg_addr_t rf_raddr_b_o;
  rv_isa_pkg::word_t     jmp_target_o;
  logic                  id_valid_o;
  logic                  id_ready_o;
  logic                  ex_valid_o;
  logic                  ex_alu_en_o;
  rv_isa_pkg::alu_op_e   ex_alu_op_o;
  logic                  ex_bch_o;
  logic                  ex_jmp_o;
  rv_isa_pkg::word_t     ex_operand_a_o;
  rv_isa_pkg::word_t     ex_operand_b_o;
  rv_isa_pkg::word_t     ex_operand_c_o;
  logic                  ex_rf_we_o;
  rv_isa_pkg::reg_addr_t ex_rf_waddr_o;
  logic                  ex_illegal_o;
  rv_isa_pkg::word_t     ex_pc_o;
  int                    mismatch_cnt;
  int                    cycle_cnt = 0;
  logic [31:0]           rng_state;

  decode_stage dut_i (.*);

  decode_checker checker_i (.*, .mismatch_cnt_o(mismatch_cnt));

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////
  // Random source
  ////////////////////
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Legal opcode with random fields
  // About one in eight words gets an illegal opcode
  function automatic rv_isa_pkg::word_t build_instr();
    logic [31:0] w;
    logic [31:0] pick;
    logic [6:0]  opc;
    w    = next_rand();
    pick = next_rand();
    case (pick % 7)
      0:       opc = 7'h33;
      1:       opc = 7'h13;
      2:       opc = 7'h37;
      3:       opc = 7'h17;
      4:       opc = 7'h6f;
      5:       opc = 7'h67;
      default: opc = 7'h63;
    endcase
    // Mostly valid funct7 for R-type and shifts
    // Left random now and then
    if ((opc == 7'h33 || (opc == 7'h13 && w[13:12] == 2'b01)) && pick[11:9] != 3'd0) begin
      w[31:25] = pick[8] ? 7'h20 : 7'h00;
    end
    if (opc == 7'h67) begin
      w[14:12] = 3'd0;
    end
    // Load, store, system or fence
    if (pick[5:3] == 3'd0) begin
      case (pick[13:12])
        2'd0:    opc = 7'h03;
        2'd1:    opc = 7'h23;
        2'd2:    opc = 7'h73;
        default: opc = 7'h0f;
      endcase
    end
    return {w[31:7], opc};
  endfunction

  task automatic drive_cycle();
    logic [31:0] r;
    // New word only once the previous one left ID
    if (id_ready_o) begin
      instr_i       = build_instr();
      r             = next_rand();
      pc_i          = {r[31:2], 2'b00};
      instr_valid_i = (r[1:0] != 2'd0) || r[2];
    end
    r            = next_rand();
    ex_ready_i   = (r[1:0] != 2'd0);
    kill_i       = (r[7:4] == 4'd0);
    halt_i       = (r[10:8] == 3'd0);
    fw_a_sel_i   = id_ctrl_pkg::fw_sel_e'(r[20:16] % 3);
    fw_b_sel_i   = id_ctrl_pkg::fw_sel_e'(r[28:24] % 3);
    rf_rdata_a_i = next_rand();
    rf_rdata_b_i = next_rand();
    wdata_ex_i   = next_rand();
    wdata_wb_i   = next_rand();
  endtask

  task automatic print_counts();
    $display("Error count: %0d value mismatches", mismatch_cnt);
  endtask

  ////////////////////
  // Main sequence
  ////////////////////
  initial begin
    rng_state     = 32'd99980;
    rst_n         = 1'b0;
    instr_i       = '0;
    pc_i          = '0;
    instr_valid_i = 1'b0;
    kill_i        = 1'b0;
    halt_i        = 1'b0;
    fw_a_sel_i    = id_ctrl_pkg::SEL_REGFILE;
    fw_b_sel_i    = id_ctrl_pkg::SEL_REGFILE;
    rf_rdata_a_i  = '0;
    rf_rdata_b_i  = '0;
    wdata_ex_i    = '0;
    wdata_wb_i    = '0;
    ex_ready_i    = 1'b1;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    repeat (NUM_CYCLES) begin
      drive_cycle();
      @(negedge clk);
    end
    // Let the last falling-edge compare settle
    @(negedge clk);
    #1;
    print_counts();
    if (mismatch_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("ERROR: run did not end within %0d cycles, stopping", TIMEOUT_CYCLES);
      print_counts();
      $display("Something failed");
      $finish;
    end
  end

endmodule

// ==== verilog.f ====
+incdir+rtl
rtl/rv_isa_pkg.sv
rtl/id_ctrl_pkg.sv
rtl/operand_sel_if.sv
rtl/instr_decoder.sv
rtl/operand_path.sv
rtl/id_ex_register.sv
rtl/decode_stage.sv
bench/decode_checker.sv
bench/decode_stage_tb.sv

// ==== Bender.yml ====
package:
  name: decode_stage

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/rv_isa_pkg.sv
      - rtl/id_ctrl_pkg.sv
      - rtl/operand_sel_if.sv
      - rtl/instr_decoder.sv
      - rtl/operand_path.sv
      - rtl/id_ex_register.sv
      - rtl/decode_stage.sv
  - target: simulation
    files:
      - bench/decode_checker.sv
      - bench/decode_stage_tb.sv
